// File: cft_mini.f
hw/cft_pkg.sv
hw/ibus_if.sv
hw/mem_bus_if.sv
hw/card_ctl.sv
hw/card_reg.sv
hw/card_alu.sv
hw/card_mem.sv
hw/cft_mini.sv
verification/cft_mini_assertions.sv
verification/cft_mini_tb.sv

// File: hw/card_alu.sv
`timescale 1ns/1ps

module card_alu (
   input  logic           clk,
   input  logic           rst,
   ibus_if.alu            bus,
   input  cft_pkg::word_t db_r
);
   import cft_pkg::*;

   logic  l_q;    // Link flag
   logic  carry;  // Adder carry-out
   word_t sum;    // Adder result mod 2^16

   assign {carry, sum} = {1'b0, bus.ac} + {1'b0, db_r};

   //////////////////////////////
   // Result mux
   //////////////////////////////

   always_comb begin
      case (bus.action)
         ACT_PASS: bus.alu_out = db_r;          // LOAD
         ACT_ADD:  bus.alu_out = sum;
         ACT_AND:  bus.alu_out = bus.ac & db_r;
         ACT_XOR:  bus.alu_out = bus.ac ^ db_r;
         ACT_NOT:  bus.alu_out = ~bus.ac;
         default:  bus.alu_out = bus.ac;        // NONE and CLL leave AC alone
      endcase
   end

   //////////////////////////////
   // Flags
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         l_q <= 1'b0;
      end else begin
         case (bus.action)
            ACT_ADD: l_q <= carry;              // Carry out of bit 15
            ACT_CLL: l_q <= 1'b0;
            default: l_q <= l_q;                // Held on every other action
         endcase
      end
   end

   assign bus.fl = l_q;
   assign bus.fz = (bus.ac == '0);              // Live, not latched

endmodule

// File: hw/card_ctl.sv
`timescale 1ns/1ps

module card_ctl (
   input  logic       clk,
   input  logic       rst,
   input  logic       run,
   ibus_if.ctl        bus,
   mem_bus_if.cpu_ctl mem,
   output logic       halted
);
   import cft_pkg::*;

   typedef enum logic [2:0] {
      ST_IDLE, ST_FETCH, ST_DECODE, ST_EXEC, ST_WB, ST_HALTED
   } state_t;

   state_t    state, state_nxt;
   op_t       op;          // Opcode held in IR
   logic      fetch_halt;  // Word on db_r is a HALT
   logic      op_reads;    // Operand comes from memory
   alu_act_t  op_act;      // ALU action for WB
   ibus_dst_t op_dst;      // Register target for WB

   assign op         = opcode_of(bus.ir);
   assign fetch_halt = (opcode_of(mem.db_r) == OP_HALT);
   assign halted     = (state == ST_HALTED);

   //////////////////////////////
   // Sequencer
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) state <= ST_IDLE;
      else     state <= state_nxt;
   end

   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE:   if (run) state_nxt = ST_FETCH;                     // Wait for panel
         ST_FETCH:  state_nxt = ST_DECODE;
         ST_DECODE: state_nxt = fetch_halt ? ST_HALTED : ST_EXEC;
         ST_EXEC:   state_nxt = ST_WB;
         ST_WB:     state_nxt = ST_FETCH;
         default:   state_nxt = state;                                 // HALTED sticks
      endcase
   end

   //////////////////////////////
   // Opcode decode
   //////////////////////////////

   always_comb begin
      op_act   = ACT_NONE;
      op_dst   = DST_NONE;
      op_reads = 1'b0;
      case (op)
         OP_LOAD: begin
            op_act   = ACT_PASS;
            op_dst   = DST_AC;
            op_reads = 1'b1;
         end
         OP_ADD: begin
            op_act   = ACT_ADD;                                        // Carry into L
            op_dst   = DST_AC;
            op_reads = 1'b1;
         end
         OP_AND: begin
            op_act   = ACT_AND;
            op_dst   = DST_AC;
            op_reads = 1'b1;
         end
         OP_XOR: begin
            op_act   = ACT_XOR;
            op_dst   = DST_AC;
            op_reads = 1'b1;
         end
         OP_NOT: begin
            op_act = ACT_NOT;                                          // No operand needed
            op_dst = DST_AC;
         end
         OP_CLL:  op_act = ACT_CLL;
         OP_JMP:  op_dst = DST_PC_JUMP;
         OP_JZ:   op_dst = bus.fz ? DST_PC_JUMP : DST_NONE;            // Taken on AC == 0
         OP_JL:   op_dst = bus.fl ? DST_PC_JUMP : DST_NONE;            // Taken on L set
         default: op_dst = DST_NONE;                                   // STORE, HALT, no-ops
      endcase
   end

   // Microcode fields per step
   always_comb begin
      bus.raddr  = SRC_PC;
      bus.waddr  = DST_NONE;
      bus.action = ACT_NONE;
      mem.r      = 1'b0;
      mem.w      = 1'b0;
      case (state)
         ST_FETCH:  mem.r = 1'b1;                                      // ab = PC
         ST_DECODE: bus.waddr = fetch_halt ? DST_PC_INC : DST_IR;
         ST_EXEC: begin
            bus.raddr = SRC_OPERAND;
            mem.r     = op_reads;
            mem.w     = (op == OP_STORE);                              // AC out on db_w
         end
         ST_WB: begin
            bus.action = op_act;
            bus.waddr  = op_dst;
         end
         default: ;                                                    // Quiet in IDLE, HALTED
      endcase
   end

endmodule

// File: hw/card_mem.sv
`timescale 1ns/1ps

module card_mem (
   input  logic           clk,
   mem_bus_if.mem         mem,
   input  logic           fp_we,
   input  cft_pkg::addr_t fp_addr,
   input  cft_pkg::word_t fp_wdata,
   output cft_pkg::word_t fp_rdata
);
   import cft_pkg::*;

   word_t store [MEM_WORDS];  // Core array

   //////////////////////////////
   // Writes
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (fp_we)
         store[fp_addr] <= fp_wdata;   // Panel load
      if (mem.w)
         store[mem.ab] <= mem.db_w;    // Issued last so the CPU wins a clash
   end

   //////////////////////////////
   // Registered reads
   //////////////////////////////

   // CPU port holds its last word between read strobes
   always_ff @(posedge clk) begin
      if (mem.r)
         mem.db_r <= store[mem.ab];
   end

   always_ff @(posedge clk) begin
      fp_rdata <= store[fp_addr];      // Panel sees old data on a same-edge write
   end

endmodule

// File: hw/card_reg.sv
`timescale 1ns/1ps

module card_reg (
   input  logic           clk,
   input  logic           rst,
   ibus_if.regs           bus,
   mem_bus_if.cpu_reg     mem,
   output cft_pkg::word_t ac,
   output cft_pkg::addr_t pc
);
   import cft_pkg::*;

   word_t ir_q;  // Current instruction

   //////////////////////////////
   // Register file
   //////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         pc   <= '0;
         ir_q <= '0;
         ac   <= '0;
      end else begin
         case (bus.waddr)
            DST_IR: begin
               ir_q <= mem.db_r;                 // Fetched word
               pc   <= pc + 1'b1;                // Step past it
            end
            DST_AC:      ac <= bus.alu_out;
            DST_PC_INC:  pc <= pc + 1'b1;        // Step only, IR kept
            DST_PC_JUMP: pc <= operand_of(ir_q); // Direct target
            default: ;
         endcase
      end
   end

   // IBus read side
   assign bus.ir = ir_q;
   assign bus.ac = ac;

   //////////////////////////////
   // Memory bus drivers
   //////////////////////////////

   assign mem.ab   = (bus.raddr == SRC_PC) ? pc : operand_of(ir_q);
   assign mem.db_w = ac;                         // STORE always writes AC

endmodule

// File: hw/cft_mini.sv
`timescale 1ns/1ps

module cft_mini (
   input  logic           clk,
   input  logic           rst,
   input  logic           run,       // Start from the panel
   input  logic           fp_we,
   input  cft_pkg::addr_t fp_addr,
   input  cft_pkg::word_t fp_wdata,
   output cft_pkg::word_t fp_rdata,
   output logic           halted,
   output cft_pkg::word_t ac,
   output cft_pkg::addr_t pc
);

   //////////////////////////////
   // Backplane
   //////////////////////////////

   ibus_if    ibus ();               // Microcode bus
   mem_bus_if mbus ();               // Memory transactions

   //////////////////////////////
   // Cards
   //////////////////////////////

   card_ctl u_ctl (.clk(clk), .rst(rst), .run(run), .bus(ibus), .mem(mbus),
                   .halted(halted));

   card_reg u_reg (.clk(clk), .rst(rst), .bus(ibus), .mem(mbus), .ac(ac), .pc(pc));

   card_alu u_alu (.clk(clk), .rst(rst), .bus(ibus),
                   .db_r(mbus.db_r));                   // Operand straight off the bus

   card_mem u_mem (
      .clk      (clk),
      .mem      (mbus),
      .fp_we    (fp_we),
      .fp_addr  (fp_addr),
      .fp_wdata (fp_wdata),
      .fp_rdata (fp_rdata)
   );

endmodule

// File: hw/cft_pkg.sv
package cft_pkg;

   //////////////////////////////
   // Sizes
   //////////////////////////////

   localparam int WORD_W    = 16;   // Data word
   localparam int ADDR_W    = 8;    // Direct address field
   localparam int MEM_WORDS = 256;  // Full direct address space

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [ADDR_W-1:0] addr_t;

   //////////////////////////////
   // Instruction set
   //////////////////////////////

   typedef enum logic [3:0] {
      OP_HALT  = 4'd0,
      OP_LOAD  = 4'd1,
      OP_STORE = 4'd2,
      OP_ADD   = 4'd3,
      OP_AND   = 4'd4,
      OP_XOR   = 4'd5,
      OP_NOT   = 4'd6,
      OP_JMP   = 4'd7,
      OP_JZ    = 4'd8,
      OP_JL    = 4'd9,
      OP_CLL   = 4'd10   // 11 to 15 run as no-ops
   } op_t;

   // Microcode fields carried on the ibus
   typedef enum logic [2:0] {
      ACT_NONE, ACT_PASS, ACT_ADD, ACT_AND, ACT_XOR, ACT_NOT, ACT_CLL
   } alu_act_t;

   typedef enum logic {SRC_PC, SRC_OPERAND} ibus_src_t;         // Address bus source

   typedef enum logic [2:0] {
      DST_NONE, DST_IR, DST_AC, DST_PC_INC, DST_PC_JUMP
   } ibus_dst_t;

   function automatic op_t opcode_of(word_t w);
      return op_t'(w[15:12]);                                     // Top nibble
   endfunction

   function automatic addr_t operand_of(word_t w);
      return w[ADDR_W-1:0];                                       // Low byte
   endfunction

endpackage

// File: hw/ibus_if.sv
`timescale 1ns/1ps

interface ibus_if;
   import cft_pkg::*;

   ibus_src_t raddr;   // Address source, from CTL
   ibus_dst_t waddr;   // Register write target, from CTL
   alu_act_t  action;  // ALU action, from CTL
   word_t     ir;      // Instruction register, from REG
   word_t     ac;      // Accumulator, from REG
   word_t     alu_out; // ALU result, from ALU
   logic      fz;      // AC is zero
   logic      fl;      // Link flag

   modport ctl (
      output raddr, waddr, action,
      input  ir, fz, fl
   );

   modport regs (
      input  raddr, waddr, alu_out,
      output ir, ac
   );

   modport alu (
      input  action, ac,
      output alu_out, fz, fl
   );

endinterface

// File: hw/mem_bus_if.sv
`timescale 1ns/1ps

interface mem_bus_if;
   import cft_pkg::*;

   addr_t ab;    // Address bus, from REG
   word_t db_w;  // Write data, always AC
   logic  r;     // Read strobe
   logic  w;     // Write strobe
   word_t db_r;  // Read data, one cycle after r

   modport cpu_reg (output ab, db_w, input db_r);

   // CTL peeks at db_r to catch HALT during decode
   modport cpu_ctl (output r, w, input db_r);

   modport mem (
      input  ab, db_w, r, w,
      output db_r
   );

endinterface

// File: verification/cft_mini_assertions.sv
`timescale 1ns/1ps

module cft_mini_assertions (
   input logic clk,
   input logic rst,
   input logic r,        // Memory read strobe
   input logic w,        // Memory write strobe
   input logic halted,
   input logic idle,     // Sequencer in IDLE
   input logic stopped   // Sequencer in HALTED
);

   // One transaction per cycle on the shared address bus
   a_one_strobe: assert property (@(posedge clk) disable iff (rst) !(r && w))
      else $error("r and w strobes high together");

   a_halted_sticks: assert property (@(posedge clk) disable iff (rst) halted |=> halted)
      else $error("halted dropped without reset");

   a_quiet: assert property (@(posedge clk) disable iff (rst) (idle || stopped) |-> (!r && !w))
      else $error("memory strobe active while IDLE or HALTED");

   a_no_exit: assert property (@(posedge clk) (stopped && !rst) |=> (stopped || rst))
      else $error("sequencer left HALTED without reset");

endmodule

bind card_ctl cft_mini_assertions u_assert (
   .clk(clk), .rst(rst), .r(mem.r), .w(mem.w), .halted(halted),
   .idle(state == ST_IDLE), .stopped(state == ST_HALTED)
);

// File: verification/cft_mini_tb.sv
`timescale 1ns/1ps

module cft_mini_tb;
   import cft_pkg::*;

   localparam int     NUM_TESTS   = 12;
   localparam int     RUN_CYCLES  = 64 * 4;                          // Longest program
   localparam int     LOAD_CYCLES = 12 + MEM_WORDS + 20 + 2 * 128 + 40;  // Reset, load, idle, readback
   localparam longint WATCHDOG_NS = longint'(NUM_TESTS) * (RUN_CYCLES + LOAD_CYCLES) * 100 + 20000;

   logic  clk = 1'b0;
   logic  rst, run, fp_we, halted;
   addr_t fp_addr, pc;
   word_t fp_wdata, fp_rdata, ac;

   int unsigned seed = 16;       // LCG state
   int          errors = 0;
   int          failed_tests = 0;
   word_t       image [MEM_WORDS];      // Program and data as loaded
   word_t       model_mem [MEM_WORDS];  // Memory after the model run
   word_t       m_ac;
   logic        m_l;
   addr_t       m_halt;
   string       kind_names [3] = '{"alu", "store", "jump"};

   cft_mini uut (.clk(clk), .rst(rst), .run(run), .fp_we(fp_we), .fp_addr(fp_addr),
                 .fp_wdata(fp_wdata), .fp_rdata(fp_rdata), .halted(halted), .ac(ac), .pc(pc));

   always #50 clk = ~clk;        // 100 ns period

   function automatic int unsigned rand_next();
      seed = seed * 32'd1103515245 + 32'd12345;
      return seed >> 8;                                // Drop the weak low bits
   endfunction

   //////////////////////////////
   // Compare tasks
   //////////////////////////////

   task automatic check_word(input string name, input word_t exp, input word_t act);
      if (act !== exp) begin
         $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_addr(input string name, input addr_t exp, input addr_t act);
      if (act !== exp) begin
         $display("CHECK FAILED %s: expected %0d, actual %0d", name, exp, act);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("CHECK FAILED %s: expected %b, actual %b", name, exp, act);
         errors++;
      end
   endtask

   //////////////////////////////
   // Program generator
   //////////////////////////////

   function automatic logic [3:0] pick_op(input int kind);
      logic [3:0]  alu_ops [6] = '{OP_LOAD, OP_ADD, OP_AND, OP_XOR, OP_NOT, OP_CLL};
      int unsigned r;
      r = rand_next();
      if (kind != 0 && r % 4 == 0) return OP_STORE;
      if (kind == 2 && r % 4 == 1) return 4'(7 + (r >> 4) % 3);     // JMP, JZ or JL
      if (r % 16 == 15) return 4'(11 + (r >> 4) % 5);               // No-op codes
      return alu_ops[(r >> 2) % 6];
   endfunction

   task automatic build_program(input int kind);
      int         len;
      logic [3:0] op;
      addr_t      opnd;
      for (int a = 0; a < MEM_WORDS; a++) begin
         image[a] = word_t'(rand_next());
         if (a >= 128 && rand_next() % 4 == 0) image[a] = '0;       // Zeros for AND and JZ
      end
      len = 4 + rand_next() % 60;                                   // HALT at 4 to 63
      for (int i = 0; i < len; i++) begin
         op = pick_op(kind);
         case (op)
            OP_JMP, OP_JZ, OP_JL: opnd = addr_t'(i + 1 + rand_next() % (len - i));  // Forward only
            OP_LOAD, OP_STORE, OP_ADD, OP_AND, OP_XOR: opnd = addr_t'(128 + rand_next() % 128);
            default: opnd = addr_t'(rand_next());                   // Ignored field
         endcase
         image[i] = {op, 4'(rand_next()), opnd};
      end
      image[len] = {OP_HALT, 12'h000};
   endtask

   //////////////////////////////
   // Reference model
   //////////////////////////////

   task automatic run_model();
      addr_t       p;
      word_t       ir;
      addr_t       a;
      logic [16:0] sum;
      p         = '0;
      m_ac      = '0;
      m_l       = 1'b0;
      m_halt    = '0;
      model_mem = image;
      repeat (64) begin                                             // Forward jumps bound the walk
         ir = model_mem[p];
         a  = ir[7:0];
         if (ir[15:12] == OP_HALT) begin
            m_halt = p;
            return;
         end
         p = p + 1'b1;
         case (ir[15:12])
            OP_LOAD:  m_ac = model_mem[a];
            OP_STORE: model_mem[a] = m_ac;
            OP_ADD: begin
               sum  = m_ac + model_mem[a];                          // 17 bit sum
               m_ac = sum[15:0];
               m_l  = sum[16];
            end
            OP_AND:  m_ac = m_ac & model_mem[a];
            OP_XOR:  m_ac = m_ac ^ model_mem[a];
            OP_NOT:  m_ac = ~m_ac;
            OP_JMP:  p = a;
            OP_JZ:   if (m_ac == '0) p = a;
            OP_JL:   if (m_l) p = a;
            OP_CLL:  m_l = 1'b0;
            default: ;                                              // 11 to 15
         endcase
      end
   endtask

   //////////////////////////////
   // Front panel and reset
   //////////////////////////////

   task automatic reset_dut(input string name);
      @(posedge clk) rst <= 1'b1;
      repeat (10) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_bit({name, " halted after reset"}, 1'b0, halted);
      check_word({name, " ac after reset"}, '0, ac);
      check_addr({name, " pc after reset"}, '0, pc);
   endtask

   task automatic load_image();
      for (int a = 0; a < MEM_WORDS; a++) begin
         @(posedge clk);
         fp_we    <= 1'b1;
         fp_addr  <= addr_t'(a);
         fp_wdata <= image[a];
      end
      @(posedge clk);
      fp_we <= 1'b0;                                                // Last word lands here
   endtask

   task automatic read_back(input string name);
      for (int a = 128; a < MEM_WORDS; a++) begin
         @(posedge clk);
         fp_addr <= addr_t'(a);
         @(posedge clk);                                            // Registered read
         @(negedge clk);
         check_word($sformatf("%s mem[%0d]", name, a), model_mem[a], fp_rdata);
      end
   endtask

   //////////////////////////////
   // Test sequence
   //////////////////////////////

   initial begin
      int    kind;
      int    waited;
      int    errs_before;
      string name;
      rst      = 1'b1;
      run      = 1'b0;
      fp_we    = 1'b0;
      fp_addr  = '0;
      fp_wdata = '0;
      for (int t = 0; t < NUM_TESTS; t++) begin
         kind        = t % 3;
         errs_before = errors;
         name        = $sformatf("test %0d %s", t, kind_names[kind]);
         build_program(kind);
         run_model();
         reset_dut(name);
         load_image();
         repeat (1 + rand_next() % 16) @(posedge clk);              // run held low
         @(negedge clk);
         check_addr({name, " pc while idle"}, '0, pc);
         check_bit({name, " halted while idle"}, 1'b0, halted);
         @(posedge clk) run <= 1'b1;
         waited = 0;
         while (halted !== 1'b1 && waited < RUN_CYCLES + 8) begin
            @(negedge clk);
            waited++;
         end
         if (halted !== 1'b1) begin
            $display("%s: DUT did not halt within %0d cycles", name, waited);
            errors++;
         end
         check_word({name, " ac"}, m_ac, ac);
         check_addr({name, " pc"}, m_halt + 1'b1, pc);
         repeat (20) begin
            @(negedge clk);
            check_addr({name, " pc after halt"}, m_halt + 1'b1, pc);  // Frozen
         end
         read_back(name);
         @(posedge clk) run <= 1'b0;
         if (errors != errs_before) failed_tests++;
         $display("%s: %s", name, (errors == errs_before) ? "ok" : "errors found");
      end
      $display("%0d tests run, %0d failed, %0d check errors", NUM_TESTS, failed_tests, errors);
      if (errors == 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired before all tests finished");
      $display("FAIL: see errors above");
      $finish;
   end

endmodule
